//--- Bender.yml
package:
  name: ice51_uart

export_include_dirs:
  - .

sources:
  - ice51_uart_pkg.sv
  - baud_timer.sv
  - uart_rx.sv
  - uart_tx.sv
  - uart_regs.sv
  - ice51_uart.sv
  - target: test
    files:
      - tb_ice51_uart.sv

//--- baud_timer.sv
`timescale 1ns/100ps
`include "ice51_uart_defs.svh"

module baud_timer #(
   parameter int SAMPLE = `ICE51_SAMPLE
) (
   input  logic i_clk,
   input  logic i_nrst,
   input  logic i_restart,
   output logic o_half,
   output logic o_full
);

   localparam int CNT_W = $clog2(SAMPLE + 1);

   logic [CNT_W-1:0] count;
   logic [CNT_W-1:0] count_next;

   // ticks, one period is SAMPLE+1 cycles
   assign o_full = (count == CNT_W'(SAMPLE));
   assign o_half = (count == CNT_W'(SAMPLE / 2)); // start bit confirm point

   // wrap on restart or at the end of a bit
   always_comb begin
      if (i_restart || o_full) begin
         count_next = '0;
      end else begin
         count_next = count + 1'b1;
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         count <= '0;
      end else begin
         count <= count_next;
      end
   end

endmodule

//--- ice51_uart.f
+incdir+.
ice51_uart_pkg.sv
baud_timer.sv
uart_rx.sv
uart_tx.sv
uart_regs.sv
ice51_uart.sv
tb_ice51_uart.sv

//--- ice51_uart.sv
`timescale 1ns/100ps
`include "ice51_uart_defs.svh"

module ice51_uart #(
   parameter int SAMPLE = `ICE51_SAMPLE
) (
   input  logic                       i_clk,
   input  logic                       i_nrst,
   // serial lines
   input  logic                       i_uart_rx,
   output logic                       o_uart_tx,
   // host register port
   input  logic                       i_bus_valid,
   input  logic                       i_bus_write,
   input  logic [`ICE51_ADDR_W-1:0]   i_bus_addr,
   input  ice51_uart_pkg::uart_byte_t i_bus_wdata,
   output logic                       o_bus_ready,
   output ice51_uart_pkg::uart_byte_t o_bus_rdata
);
   import ice51_uart_pkg::*;

   logic       rx_valid;
   uart_byte_t rx_data;
   logic       tx_start;
   uart_byte_t tx_data;
   logic       tx_busy;

   uart_rx #(
      .SAMPLE (SAMPLE)
   ) u_rx (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .i_uart_rx  (i_uart_rx),
      .o_rx_valid (rx_valid),
      .o_rx_data  (rx_data)
   );

   uart_tx #(
      .SAMPLE (SAMPLE)
   ) u_tx (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .i_tx_start (tx_start),
      .i_tx_data  (tx_data),
      .o_tx_busy  (tx_busy),
      .o_uart_tx  (o_uart_tx)
   );

   uart_regs u_regs (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_bus_valid (i_bus_valid),
      .i_bus_write (i_bus_write),
      .i_bus_addr  (i_bus_addr),
      .i_bus_wdata (i_bus_wdata),
      .o_bus_ready (o_bus_ready),
      .o_bus_rdata (o_bus_rdata),
      .i_rx_valid  (rx_valid),
      .i_rx_data   (rx_data),
      .o_tx_start  (tx_start),
      .o_tx_data   (tx_data),
      .i_tx_busy   (tx_busy)
   );

endmodule

//--- ice51_uart_defs.svh
`ifndef ICE51_UART_DEFS_SVH
`define ICE51_UART_DEFS_SVH

// clock cycles counted per bit, bit period is one more
`define ICE51_SAMPLE 104

// host address width, same as dptr
`define ICE51_ADDR_W 16

////////////////////
// register map
`define ICE51_ADDR_TX_BUSY 16'h0200 // transmitter busy (rd)
`define ICE51_ADDR_TX_DATA 16'h0201 // transmit data (wr)
`define ICE51_ADDR_RX_PEND 16'h0202 // receive pending (rd)
`define ICE51_ADDR_RX_DATA 16'h0203 // receive data (rd, clears pending)

// start + 8 data + stop
`define ICE51_FRAME_BITS 10

`endif

//--- ice51_uart_pkg.sv
package ice51_uart_pkg;

   // one byte on the serial line
   typedef logic [7:0] uart_byte_t;

   ////////////////////
   // receiver fsm
   // gray-ish order, idle -> start -> data -> stop wait
   typedef enum logic [1:0] {
      RX_IDLE  = 2'b00,
      RX_START = 2'b01, // waiting for mid start bit
      RX_DATA  = 2'b11, // sampling data bits
      RX_WAIT  = 2'b10  // stop bit wait
   } rx_state_e;

   ////////////////////
   // transmitter fsm
   typedef enum logic [1:0] {
      TX_IDLE  = 2'b00,
      TX_START = 2'b01, // line held low
      TX_SEND  = 2'b10  // data bits then stop
   } tx_state_e;

endpackage

//--- tb_ice51_uart.sv
`timescale 1ns/100ps
`include "ice51_uart_defs.svh"

module tb_ice51_uart;
   import ice51_uart_pkg::*;

   localparam int SAMPLE     = 15;
   localparam int BIT_CYC    = SAMPLE + 1;
   localparam int RST_CYCLES = 10;
   localparam int N_TX       = 4;
   localparam int N_RX       = 4;
   localparam int N_FRAMES   = N_TX + 2 + N_RX + 2; // plus back-pressure and overrun pairs
   localparam int TIMEOUT    = 2 * (N_FRAMES * `ICE51_FRAME_BITS * BIT_CYC) + RST_CYCLES;

   logic                     i_clk;
   logic                     i_nrst;
   logic                     i_uart_rx;
   logic                     o_uart_tx;
   logic                     i_bus_valid;
   logic                     i_bus_write;
   logic [`ICE51_ADDR_W-1:0] i_bus_addr;
   uart_byte_t               i_bus_wdata;
   logic                     o_bus_ready;
   uart_byte_t               o_bus_rdata;

   logic [31:0] lfsr_state;
   uart_byte_t  tx_expect[$];  // written, not yet seen on the line
   uart_byte_t  rx_buf_model;
   logic        rx_pend_model;
   int          value_errs;
   int          line_errs;
   int          last_stalls;    // ready-low cycles of the last transfer
   int          cycle_cnt;

   ice51_uart #(
      .SAMPLE (SAMPLE)
   ) UUT (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_uart_rx   (i_uart_rx),
      .o_uart_tx   (o_uart_tx),
      .i_bus_valid (i_bus_valid),
      .i_bus_write (i_bus_write),
      .i_bus_addr  (i_bus_addr),
      .i_bus_wdata (i_bus_wdata),
      .o_bus_ready (o_bus_ready),
      .o_bus_rdata (o_bus_rdata)
   );

   initial begin
      i_clk = 1'b0;
      forever #50 i_clk = ~i_clk;
   end

   // run limit
   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT) begin
         @(posedge i_clk);
         cycle_cnt++;
      end
      $display("timeout: run did not finish within %0d cycles", TIMEOUT);
      $display("Test FAILED");
      $finish;
   end

   ////////////////////
   // helpers
   // taps 32 22 2 1, one step per bit
   function automatic uart_byte_t rand_byte();
      uart_byte_t b;
      logic       fb;
      b = '0;
      for (int i = 0; i < 8; i++) begin
         fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         b          = {b[6:0], fb};
      end
      return b;
   endfunction

   task automatic check_byte(input string what, input uart_byte_t got, input uart_byte_t exp);
      if (got !== exp) begin
         $display("[FAIL] %0t ns: %s, got %02h expected %02h", $time, what, got, exp);
         value_errs++;
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         $display("[FAIL] %0t ns: %s, got %b expected %b", $time, what, got, exp);
         value_errs++;
      end
   endtask

   // ends 10 ns after a rising edge
   task automatic wait_cycles(input int n);
      repeat (n) @(posedge i_clk);
      #10;
   endtask

   // one host transfer, held until ready
   task automatic bus_xfer(input logic wr, input logic [`ICE51_ADDR_W-1:0] addr,
                           input uart_byte_t wdata, output uart_byte_t rdata);
      i_bus_valid = 1'b1;
      i_bus_write = wr;
      i_bus_addr  = addr;
      i_bus_wdata = wdata;
      last_stalls = 0;
      @(negedge i_clk);
      while (!o_bus_ready) begin
         last_stalls++;
         @(negedge i_clk);
      end
      rdata = o_bus_rdata; // valid in the completing cycle
      @(posedge i_clk);
      #10;
      i_bus_valid = 1'b0;
      i_bus_write = 1'b0;
   endtask

   task automatic bus_write(input logic [`ICE51_ADDR_W-1:0] addr, input uart_byte_t data);
      uart_byte_t rd_dummy;
      bus_xfer(1'b1, addr, data, rd_dummy);
   endtask

   task automatic bus_read(input logic [`ICE51_ADDR_W-1:0] addr, output uart_byte_t data);
      bus_xfer(1'b0, addr, 8'h00, data);
   endtask

   task automatic poll_flag(input logic [`ICE51_ADDR_W-1:0] addr, input logic level);
      uart_byte_t rd;
      bus_read(addr, rd);
      while (rd[0] !== level) begin
         bus_read(addr, rd);
      end
   endtask

   task automatic write_tx(input uart_byte_t b);
      tx_expect.push_back(b);
      bus_write(`ICE51_ADDR_TX_DATA, b);
   endtask

   ////////////////////
   // serial line model
   task automatic send_frame(input uart_byte_t b);
      logic [`ICE51_FRAME_BITS-1:0] bits;
      bits = {1'b1, b, 1'b0}; // stop, data, start
      for (int i = 0; i < `ICE51_FRAME_BITS; i++) begin
         i_uart_rx = bits[i];
         wait_cycles(BIT_CYC);
      end
      // buffer rule, a byte is dropped while one is pending
      if (!rx_pend_model) begin
         rx_buf_model  = b;
         rx_pend_model = 1'b1;
      end
   endtask

   task automatic read_rx();
      uart_byte_t rd;
      bus_read(`ICE51_ADDR_RX_DATA, rd);
      check_byte("rx data", rd, rx_buf_model);
      rx_pend_model = 1'b0;
      bus_read(`ICE51_ADDR_RX_PEND, rd);
      check_byte("rx pending after data read", rd, {7'd0, rx_pend_model});
   endtask

   // frame decoder on o_uart_tx, mid-bit sampling
   initial begin : tx_monitor
      uart_byte_t got;
      logic       bad;
      wait (i_nrst === 1'b1);
      forever begin
         @(negedge i_clk);
         if (o_uart_tx === 1'b0) begin
            bad = 1'b0;
            repeat (BIT_CYC / 2) @(negedge i_clk);
            if (o_uart_tx !== 1'b0) bad = 1'b1; // start bit too short
            for (int i = 0; i < 8; i++) begin
               repeat (BIT_CYC) @(negedge i_clk);
               got[i] = o_uart_tx;
            end
            repeat (BIT_CYC) @(negedge i_clk);
            if (o_uart_tx !== 1'b1) bad = 1'b1; // no stop bit
            if (bad) begin
               $display("framing error at %0t ns: bad start or stop bit on o_uart_tx", $time);
               line_errs++;
            end else if (tx_expect.size() == 0) begin
               $display("unexpected frame on o_uart_tx at %0t ns", $time);
               line_errs++;
            end else begin
               check_byte("tx frame", got, tx_expect.pop_front());
            end
         end
      end
   end

   ////////////////////
   // test sequence
   initial begin : main
      uart_byte_t rd;
      uart_byte_t b;
      lfsr_state    = 32'h775e8e86;
      value_errs    = 0;
      line_errs     = 0;
      last_stalls   = 0;
      rx_pend_model = 1'b0;
      rx_buf_model  = '0;
      i_nrst        = 1'b0;
      i_uart_rx     = 1'b1;
      i_bus_valid   = 1'b0;
      i_bus_write   = 1'b0;
      i_bus_addr    = '0;
      i_bus_wdata   = '0;
      wait_cycles(RST_CYCLES);
      i_nrst = 1'b1;

      // reset state
      @(negedge i_clk);
      check_flag("o_uart_tx after reset", o_uart_tx, 1'b1);
      check_flag("o_bus_ready after reset", o_bus_ready, 1'b1);
      wait_cycles(1);
      bus_read(`ICE51_ADDR_TX_BUSY, rd);
      check_byte("busy after reset", rd, 8'h00);
      bus_read(`ICE51_ADDR_RX_PEND, rd);
      check_byte("pending after reset", rd, 8'h00);
      bus_read({8'h03, rand_byte()}, rd);
      check_byte("unmapped read", rd, 8'h00);
      bus_write({8'h03, rand_byte()}, rand_byte()); // must not start a frame
      bus_read(`ICE51_ADDR_TX_BUSY, rd);
      check_byte("busy after unmapped write", rd, 8'h00);

      // single frames
      for (int n = 0; n < N_TX; n++) begin
         write_tx(rand_byte());
         bus_read(`ICE51_ADDR_TX_BUSY, rd);
         check_byte("busy during frame", rd, 8'h01);
         poll_flag(`ICE51_ADDR_TX_BUSY, 1'b0);
         check_flag("tx frame decoded before busy fell", tx_expect.size() == 0, 1'b1);
      end

      // second write waits out the first frame
      write_tx(rand_byte());
      write_tx(rand_byte());
      check_flag("second write held by ready", last_stalls > 0, 1'b1);
      poll_flag(`ICE51_ADDR_TX_BUSY, 1'b0);
      check_flag("both frames decoded", tx_expect.size() == 0, 1'b1);

      // receive
      for (int n = 0; n < N_RX; n++) begin
         b = rand_byte();
         bus_read(`ICE51_ADDR_RX_PEND, rd);
         check_byte("pending before frame", rd, {7'd0, rx_pend_model});
         send_frame(b);
         poll_flag(`ICE51_ADDR_RX_PEND, 1'b1);
         read_rx();
      end

      // overrun, second byte lost
      send_frame(rand_byte());
      send_frame(rand_byte());
      poll_flag(`ICE51_ADDR_RX_PEND, 1'b1);
      read_rx();

      check_flag("all tx frames decoded", tx_expect.size() == 0, 1'b1);
      $display("errors: %0d value, %0d line", value_errs, line_errs);
      if (value_errs == 0 && line_errs == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

//--- uart_regs.sv
`timescale 1ns/100ps
`include "ice51_uart_defs.svh"

module uart_regs (
   input  logic                       i_clk,
   input  logic                       i_nrst,
   // host side
   input  logic                       i_bus_valid,
   input  logic                       i_bus_write,
   input  logic [`ICE51_ADDR_W-1:0]   i_bus_addr,
   input  ice51_uart_pkg::uart_byte_t i_bus_wdata,
   output logic                       o_bus_ready,
   output ice51_uart_pkg::uart_byte_t o_bus_rdata,
   // receiver
   input  logic                       i_rx_valid,
   input  ice51_uart_pkg::uart_byte_t i_rx_data,
   // transmitter
   output logic                       o_tx_start,
   output ice51_uart_pkg::uart_byte_t o_tx_data,
   input  logic                       i_tx_busy
);
   import ice51_uart_pkg::*;

   logic       hit_tx_busy;
   logic       hit_tx_data;
   logic       hit_rx_pend;
   logic       hit_rx_data;
   logic       tx_wr_req;
   logic       xfer;
   logic       rx_data_rd;
   logic       rx_accept;
   logic       rx_pending;
   uart_byte_t rx_buf;

   ////////////////////
   // address decode
   assign hit_tx_busy = (i_bus_addr == `ICE51_ADDR_TX_BUSY);
   assign hit_tx_data = (i_bus_addr == `ICE51_ADDR_TX_DATA);
   assign hit_rx_pend = (i_bus_addr == `ICE51_ADDR_RX_PEND);
   assign hit_rx_data = (i_bus_addr == `ICE51_ADDR_RX_DATA);

   // back-pressure only for a data write while a frame is going out
   assign tx_wr_req   = i_bus_valid && i_bus_write && hit_tx_data;
   assign o_bus_ready = !(tx_wr_req && i_tx_busy);
   assign xfer        = i_bus_valid && o_bus_ready;

   ////////////////////
   // transmit launch, busy is low whenever this fires
   assign o_tx_start = xfer && i_bus_write && hit_tx_data;
   assign o_tx_data  = i_bus_wdata;

   ////////////////////
   // receive buffer
   assign rx_data_rd = xfer && !i_bus_write && hit_rx_data;
   assign rx_accept  = i_rx_valid && !rx_pending; // dropped if not read yet

   always_ff @(posedge i_clk) begin
      if (rx_accept) begin
         rx_buf <= i_rx_data;
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_pending <= 1'b0;
      end else if (rx_pending) begin
         rx_pending <= !rx_data_rd; // cleared by the data read
      end else begin
         rx_pending <= rx_accept;
      end
   end

   // read mux, unmapped reads give zero
   always_comb begin
      if (hit_tx_busy) begin
         o_bus_rdata = {7'd0, i_tx_busy};
      end else if (hit_rx_pend) begin
         o_bus_rdata = {7'd0, rx_pending};
      end else if (hit_rx_data) begin
         o_bus_rdata = rx_buf;
      end else begin
         o_bus_rdata = '0;
      end
   end

endmodule

//--- uart_rx.sv
`timescale 1ns/100ps
`include "ice51_uart_defs.svh"

module uart_rx #(
   parameter int SAMPLE = `ICE51_SAMPLE
) (
   input  logic                       i_clk,
   input  logic                       i_nrst,
   input  logic                       i_uart_rx,
   output logic                       o_rx_valid,
   output ice51_uart_pkg::uart_byte_t o_rx_data
);
   import ice51_uart_pkg::*;

   localparam uart_byte_t MARKER = 8'h80; // walks down to bit 0

   logic       rx_meta;
   logic       rx_sync;
   rx_state_e  state;
   rx_state_e  state_next;
   uart_byte_t shift;
   logic       restart;
   logic       half_tick;
   logic       full_tick;
   logic       start_seen;
   logic       rx_done;

   ////////////////////
   // line resync, idles high
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= i_uart_rx;
         rx_sync <= rx_meta;
      end
   end

   baud_timer #(
      .SAMPLE (SAMPLE)
   ) u_timer (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .i_restart (restart),
      .o_half    (half_tick),
      .o_full    (full_tick)
   );

   assign start_seen = (state == RX_IDLE) && !rx_sync;
   assign rx_done    = (state == RX_WAIT) && full_tick;

   // timer held at zero in idle, realigned at mid start and after each bit
   assign restart = (state == RX_IDLE) ||
                    ((state == RX_START) && half_tick) ||
                    ((state == RX_DATA) && full_tick);

   ////////////////////
   // receive fsm
   always_comb begin
      state_next = state;
      case (state)
         RX_IDLE:  if (start_seen) state_next = RX_START;
         RX_START: if (half_tick) state_next = rx_sync ? RX_IDLE : RX_DATA; // glitch check
         RX_DATA:  if (full_tick && shift[0]) state_next = RX_WAIT; // marker at bit 0
         RX_WAIT:  if (full_tick) state_next = RX_IDLE;
         default:  state_next = RX_IDLE;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= RX_IDLE;
      end else begin
         state <= state_next;
      end
   end

   // data enters from the top, lsb first on the line
   always_ff @(posedge i_clk) begin
      if (start_seen) begin
         shift <= MARKER;
      end else if ((state == RX_DATA) && full_tick) begin
         shift <= {rx_sync, shift[7:1]};
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_rx_valid <= 1'b0;
      end else begin
         o_rx_valid <= rx_done; // end of stop wait
      end
   end

   assign o_rx_data = shift; // held through the valid cycle

endmodule

//--- uart_tx.sv
`timescale 1ns/100ps
`include "ice51_uart_defs.svh"

module uart_tx #(
   parameter int SAMPLE = `ICE51_SAMPLE
) (
   input  logic                       i_clk,
   input  logic                       i_nrst,
   input  logic                       i_tx_start,
   input  ice51_uart_pkg::uart_byte_t i_tx_data,
   output logic                       o_tx_busy,
   output logic                       o_uart_tx
);
   import ice51_uart_pkg::*;

   tx_state_e  state;
   tx_state_e  state_next;
   uart_byte_t shift;
   logic [3:0] bit_cnt;
   logic [3:0] bit_cnt_inc;
   logic       idle;
   logic       full_tick;
   logic       frame_done;

   assign idle = (state == TX_IDLE);

   // timer sits at zero until a frame starts
   baud_timer #(
      .SAMPLE (SAMPLE)
   ) u_timer (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .i_restart (idle),
      .o_half    (),
      .o_full    (full_tick)
   );

   ////////////////////
   // bit slot counter
   assign bit_cnt_inc = bit_cnt + 4'd1;
   assign frame_done  = (state == TX_SEND) && full_tick &&
                        (bit_cnt_inc == 4'(`ICE51_FRAME_BITS));

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         bit_cnt <= 4'd0;
      end else if (idle || frame_done) begin
         bit_cnt <= 4'd0;
      end else if (full_tick) begin
         bit_cnt <= bit_cnt_inc; // counts start bit too
      end
   end

   ////////////////////
   // transmit fsm
   always_comb begin
      state_next = state;
      case (state)
         TX_IDLE:  if (i_tx_start) state_next = TX_START;
         TX_START: if (full_tick) state_next = TX_SEND;
         TX_SEND:  if (frame_done) state_next = TX_IDLE;
         default:  state_next = TX_IDLE;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= TX_IDLE;
      end else begin
         state <= state_next;
      end
   end

   // ones fill from the top so the last slot is the stop bit
   always_ff @(posedge i_clk) begin
      if (idle && i_tx_start) begin
         shift <= i_tx_data;
      end else if ((state == TX_SEND) && full_tick) begin
         shift <= {1'b1, shift[7:1]};
      end
   end

   always_comb begin
      case (state)
         TX_START: o_uart_tx = 1'b0;
         TX_SEND:  o_uart_tx = shift[0];
         default:  o_uart_tx = 1'b1; // idle line
      endcase
   end

   assign o_tx_busy = !idle;

endmodule
